//--- tb.f
+incdir+.
bit_parse_pkg.sv
bit_funnel.sv
mode_header_dec.sv
bp_bpv_dec.sv
mpp_step_dec.sv
bit_parse_top.sv
tb_stream.sv
tb_top.sv

//--- tb_top.sv
`include "bit_parse_settings.svh"

module tb_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEED       = 12940;
  localparam int BLOCKS_RUN = 300;
  localparam int WAIT_LIMIT = 20000;

  logic                  clk;
  logic                  rstn;
  logic                  start_dec;
  logic                  data_avail;
  logic [`BP_WORD_W-1:0] data;
  logic                  is_next_block_fls;
  logic                  data_rd_en;
  logic                  block_valid;
  bit_parse_pkg::mode_e  mode;
  logic [2:0]            flat_type;
  logic                  csc_ycocg;
  logic [2:0]            step_size;
  logic [3:0]            use_2x2;
  logic [`BP_BPV_W-1:0]  bpv_2x2;
  logic [`BP_BPV_W-1:0]  bpv_2x1_p0;
  logic [`BP_BPV_W-1:0]  bpv_2x1_p1;
  logic [`BP_FULL_W-1:0] block_bits;
  logic [39:0]           exp_head;
  logic [39:0]           act_vec;
  logic                  exp_valid;
  logic                  stall_en;
  int                    words_taken;
  int                    blocks_seen;
  string                 test_name = "reset";
  int                    errors = 0;
  int                    err_mark = 0;
  int                    tests = 0;
  int                    failed_tests = 0;
  int                    total_blocks = 0;
  bit                    hung = 1'b0;

  bit_parse_top dut_i
  (
    .clk               (clk),
    .rstn              (rstn),
    .start_dec         (start_dec),
    .data_avail        (data_avail),
    .data              (data),
    .is_next_block_fls (is_next_block_fls),
    .data_rd_en        (data_rd_en),
    .block_valid       (block_valid),
    .mode              (mode),
    .flat_type         (flat_type),
    .csc_ycocg         (csc_ycocg),
    .step_size         (step_size),
    .use_2x2           (use_2x2),
    .bpv_2x2           (bpv_2x2),
    .bpv_2x1_p0        (bpv_2x1_p0),
    .bpv_2x1_p1        (bpv_2x1_p1),
    .block_bits        (block_bits)
  );

  tb_stream #(.SEED(SEED)) stream_i
  (
    .clk         (clk),
    .rstn        (rstn),
    .fls         (is_next_block_fls),
    .stall_en    (stall_en),
    .block_valid (block_valid),
    .data_rd_en  (data_rd_en),
    .data_avail  (data_avail),
    .data        (data),
    .exp_head    (exp_head),
    .exp_valid   (exp_valid),
    .words_taken (words_taken),
    .blocks_seen (blocks_seen)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_error(string what);
    $display("Error in %s: %s", test_name, what);
    errors++;
  endtask

  task automatic report_mismatch(logic [39:0] exp, logic [39:0] act);
    $display("Mismatch %s block fields expected %h actual %h", test_name, exp, act);
    errors++;
  endtask

  // mode, flat, csc, step, flags, 2x2, p0, p1, bit count
  assign act_vec = {mode, flat_type, csc_ycocg, step_size, use_2x2, bpv_2x2,
                    bpv_2x1_p0, bpv_2x1_p1, block_bits};

  a_block_expected: assert property (@(posedge clk) disable iff (!rstn)
    block_valid |-> exp_valid)
    else report_error("block arrived with no block left in the model");

  a_block_fields: assert property (@(posedge clk) disable iff (!rstn)
    block_valid && exp_valid |-> act_vec == exp_head)
    else report_mismatch($sampled(exp_head), $sampled(act_vec));

  a_no_read_idle: assert property (@(posedge clk) disable iff (!rstn)
    !start_dec |-> !data_rd_en)
    else report_error("data_rd_en high while start_dec is low");

  a_no_early_block: assert property (@(posedge clk) disable iff (!rstn)
    words_taken == 0 |-> !block_valid)
    else report_error("block_valid before any word was accepted");

  a_first_block: assert property (@(posedge clk) disable iff (!rstn)
    data_rd_en && words_taken == 0 |=> block_valid)
    else report_error("no block_valid one cycle after the first accepted word");

  task automatic begin_test(string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors != err_mark)
      failed_tests++;
    $display("test %-18s %s", test_name, (errors == err_mark) ? "ok" : "failed");
  endtask

  task automatic apply_reset(bit fls);
    rstn = 1'b0;
    is_next_block_fls = fls;
    repeat (10) @(negedge clk);
    rstn = 1'b1;
  endtask

  task automatic wait_blocks(int target);
    int cycles = 0;
    while (!hung && blocks_seen < target)
    begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT)
      begin
        report_error($sformatf("timeout, no block arrived within %0d cycles", WAIT_LIMIT));
        hung = 1'b1;
      end
    end
  endtask

  task automatic wait_drain();
    int cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (!hung && block_valid && cycles <= WAIT_LIMIT);
    if (block_valid)
    begin
      report_error("timeout, block_valid stayed high after start_dec fell");
      hung = 1'b1;
    end
  endtask

  task automatic run_pass(bit fls);
    string sfx = fls ? "_fls1" : "_fls0";
    apply_reset(fls);
    begin_test({"idle", sfx});
    repeat (10) @(negedge clk);
    end_test();
    begin_test({"first_block", sfx});
    start_dec = 1'b1;
    wait_blocks(1);
    end_test();
    begin_test({"steady", sfx});
    wait_blocks(BLOCKS_RUN);
    end_test();
    begin_test({"stall", sfx});
    stall_en = 1'b1;
    wait_blocks(2 * BLOCKS_RUN);
    stall_en = 1'b0;
    @(negedge clk);
    start_dec = 1'b0;
    wait_drain();
    end_test();
    @(posedge clk);
    total_blocks += blocks_seen;
    @(negedge clk);
  endtask

  initial
  begin
    rstn              = 1'b0;
    start_dec         = 1'b0;
    is_next_block_fls = 1'b0;
    stall_en          = 1'b0;
    run_pass(1'b0);
    if (!hung)
      run_pass(1'b1);
    $display("%0d tests, %0d failed, %0d errors, %0d blocks checked",
             tests, failed_tests, errors, total_blocks);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- tb_stream.sv
`include "bit_parse_settings.svh"

// bitstream model: random blocks packed into codec words, expected outputs in order
module tb_stream
#(
  parameter int SEED = 1
)
(
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  fls,
  input  logic                  stall_en,
  input  logic                  block_valid,
  input  logic                  data_rd_en,
  output logic                  data_avail,
  output logic [`BP_WORD_W-1:0] data,
  output logic [39:0]           exp_head,
  output logic                  exp_valid,
  output int                    words_taken,
  output int                    blocks_seen
);

  timeunit 1ns;
  timeprecision 1ps;

  int          seed = SEED;
  bit          bitq[$];
  logic [39:0] exp_q[$];
  logic [2:0]  prev_mode = 3'd0;
  logic        rst_seen = 1'b0;
  logic        took = 1'b0;
  logic        pend_pop = 1'b0;
  logic        have_word = 1'b0;
  int          stall_left = 0;

  function automatic int unsigned rand_bits(int n);
    return $unsigned($random(seed)) % (1 << n);
  endfunction

  // msb first, the order the parser reads
  task automatic push_bits(int unsigned val, int n);
    for (int i = n - 1; i >= 0; i--)
    begin
      bitq.push_back(val[i]);
    end
  endtask

  task automatic push_random_bits(int n);
    for (int i = 0; i < n; i++)
    begin
      bitq.push_back(1'(rand_bits(1)));
    end
  endtask

  // one random block appended to the stream, expected outputs queued
  task automatic gen_block();
    logic [2:0] mode;
    logic [2:0] flat;
    logic       csc = 1'b0;
    logic [2:0] step = 3'd0;
    logic [3:0] flags = 4'd0;
    logic [5:0] vec_a;
    logic [5:0] vec_b;
    logic [5:0] b22 = '0;
    logic [5:0] p0 = '0;
    logic [5:0] p1 = '0;
    logic [5:0] ofs = fls ? 6'(`BP_FLS_OFFSET) : 6'd0;
    int         vlen = fls ? 5 : 6;
    int         bits;
    if (rand_bits(2) == 0)
    begin
      // same flag, mode of the previous block
      mode = prev_mode;
      push_bits(1, 1);
      bits = 1;
    end
    else
    begin
      // xfm 0, bp 1, mpp 2 direct; code 3 plus escape gives mppf 3 or bpskip 4
      mode = 3'($unsigned($random(seed)) % 5);
      if (mode < 3)
        push_bits(mode, 3);
      else
        push_bits({3'b011, mode == 3'd4}, 4);
      bits = (mode < 3) ? 3 : 4;
    end
    flat = 3'(rand_bits(3));
    if (flat[2])
    begin
      // no flatness type, shows up as 4
      push_bits(0, 1);
      flat = 3'd4;
      bits += 1;
    end
    else
    begin
      push_bits({1'b1, flat[1:0]}, 3);
      bits += 3;
    end
    case (mode)
      3'd1:
      begin
        // flag 0 first, then one 2x2 vector or p1 followed by p0
        flags = 4'(rand_bits(4));
        vec_a = 6'(rand_bits(vlen));
        vec_b = 6'(rand_bits(vlen));
        push_bits({flags[0], flags[1], flags[2], flags[3]}, 4);
        push_bits(vec_a, vlen);
        if (!flags[0])
          push_bits(vec_b, vlen);
        b22 = flags[0] ? vec_a + ofs : 6'd0;
        p1  = flags[0] ? 6'd0 : vec_a + ofs;
        p0  = flags[0] ? 6'd0 : vec_b + ofs;
        bits += flags[0] ? 4 + vlen : 4 + 2 * vlen;
      end
      3'd2:
      begin
        csc  = 1'(rand_bits(1));
        step = 3'(rand_bits(3));
        push_bits({csc, step}, 4);
        push_random_bits(`BP_NUM_SAMPLES * (7 - step));
        bits += 4 + `BP_NUM_SAMPLES * (7 - step);
      end
      3'd3:
      begin
        push_random_bits(1 + `BP_MPPF_RES_BITS);
        bits += 1 + `BP_MPPF_RES_BITS;
      end
      default:
      begin
        // intra mode field, absent in fls blocks
        push_random_bits(fls ? 0 : 3);
        bits += fls ? 0 : 3;
      end
    endcase
    exp_q.push_back({mode, flat, csc, step, flags, b22, p0, p1, 8'(bits)});
    prev_mode = mode;
  endtask

  initial
  begin
    data_avail = 1'b0;
    data       = '0;
  end

  always @(posedge clk)
  begin
    rst_seen <= rstn;
  end

  always @(negedge clk)
  begin
    if (!rst_seen)
    begin
      bitq.delete();
      exp_q.delete();
      prev_mode   = 3'd0;
      words_taken = 0;
      blocks_seen = 0;
      have_word   = 1'b0;
      stall_left  = 0;
      data_avail  = 1'b0;
    end
    else
    begin
      if (took)
      begin
        words_taken++;
        have_word = 1'b0;
      end
      // block of the previous cycle was checked at the rising edge
      if (pend_pop && exp_q.size() > 0)
      begin
        void'(exp_q.pop_front());
        blocks_seen++;
      end
      if (!have_word)
      begin
        while (bitq.size() < `BP_WORD_W)
          gen_block();
        for (int i = `BP_WORD_W - 1; i >= 0; i--)
          data[i] = bitq.pop_front();
        have_word = 1'b1;
      end
      // stalls of 2 to 5 cycles
      if (stall_left == 0 && stall_en && rand_bits(3) == 0)
        stall_left = 2 + rand_bits(2);
      data_avail = (stall_left == 0);
      if (stall_left > 0)
        stall_left--;
    end
    exp_valid = exp_q.size() > 0;
    exp_head  = exp_valid ? exp_q[0] : '0;
    #1;
    took     = rst_seen && data_rd_en;
    pend_pop = rst_seen && block_valid;
  end

endmodule

//--- bit_parse_top.sv
`include "bit_parse_settings.svh"

module bit_parse_top
(
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  start_dec,
  input  logic                  data_avail,
  input  logic [`BP_WORD_W-1:0] data,
  input  logic                  is_next_block_fls,
  output logic                  data_rd_en,
  // one decoded block per cycle while high
  output logic                  block_valid,
  output bit_parse_pkg::mode_e  mode,
  output logic [2:0]            flat_type,
  output logic                  csc_ycocg,
  output logic [2:0]            step_size,
  output logic [3:0]            use_2x2,
  output logic [`BP_BPV_W-1:0]  bpv_2x2,
  output logic [`BP_BPV_W-1:0]  bpv_2x1_p0,
  output logic [`BP_BPV_W-1:0]  bpv_2x1_p1,
  output logic [`BP_FULL_W-1:0] block_bits
);

  bit_parse_pkg::head_u  head;
  logic [`BP_FULL_W-1:0] hdr_bits;
  logic [`BP_FULL_W-1:0] bp_bits;
  logic [`BP_FULL_W-1:0] mpp_bits;

  // block_valid is the funnel parse enable
  bit_funnel u_funnel
  (
    .clk        (clk),
    .rstn       (rstn),
    .start_dec  (start_dec),
    .data_avail (data_avail),
    .data       (data),
    .block_bits (block_bits),
    .data_rd_en (data_rd_en),
    .parse_en   (block_valid),
    .head       (head)
  );

  mode_header_dec u_mode_dec
  (
    .clk               (clk),
    .rstn              (rstn),
    .parse_en          (block_valid),
    .head              (head),
    .bp_bits           (bp_bits),
    .mpp_bits          (mpp_bits),
    .is_next_block_fls (is_next_block_fls),
    .mode              (mode),
    .flat_type         (flat_type),
    .hdr_bits          (hdr_bits),
    .block_bits        (block_bits)
  );

  bp_bpv_dec u_bp_dec
  (
    .head              (head),
    .hdr_bits          (hdr_bits),
    .is_next_block_fls (is_next_block_fls),
    .mode              (mode),
    .use_2x2           (use_2x2),
    .bpv_2x2           (bpv_2x2),
    .bpv_2x1_p0        (bpv_2x1_p0),
    .bpv_2x1_p1        (bpv_2x1_p1),
    .bp_bits           (bp_bits)
  );

  mpp_step_dec u_mpp_dec
  (
    .head      (head),
    .hdr_bits  (hdr_bits),
    .mode      (mode),
    .csc_ycocg (csc_ycocg),
    .step_size (step_size),
    .mpp_bits  (mpp_bits)
  );

endmodule

//--- mpp_step_dec.sv
`include "bit_parse_settings.svh"

module mpp_step_dec
(
  input  bit_parse_pkg::head_u  head,
  input  logic [`BP_FULL_W-1:0] hdr_bits,
  input  bit_parse_pkg::mode_e  mode,
  output logic                  csc_ycocg,
  output logic [2:0]            step_size,
  output logic [`BP_FULL_W-1:0] mpp_bits
);

  localparam int HEAD_W = `BP_HEAD_W;
  localparam int FULL_W = `BP_FULL_W;

  logic [HEAD_W-1:0] payload;
  logic              is_mpp;
  logic [2:0]        step_raw;
  logic [FULL_W-1:0] res_bits;

  assign payload = head << hdr_bits;
  assign is_mpp  = mode == bit_parse_pkg::mode_mpp;

  // colour space bit first, then the step size
  assign step_raw  = payload[HEAD_W-2 -: 3];
  assign csc_ycocg = is_mpp & payload[HEAD_W-1];
  assign step_size = is_mpp ? step_raw : 3'd0;

  // each sample keeps 7 - step bits, so step 7 leaves no residual
  assign res_bits = FULL_W'(`BP_NUM_SAMPLES) * FULL_W'(3'd7 - step_raw);

  // csc bit and step field precede the residuals
  assign mpp_bits = is_mpp ? FULL_W'(4) + res_bits : '0;

endmodule

//--- bp_bpv_dec.sv
`include "bit_parse_settings.svh"

module bp_bpv_dec
(
  input  bit_parse_pkg::head_u  head,
  input  logic [`BP_FULL_W-1:0] hdr_bits,
  input  logic                  is_next_block_fls,
  input  bit_parse_pkg::mode_e  mode,
  output logic [3:0]            use_2x2,
  output logic [`BP_BPV_W-1:0]  bpv_2x2,
  output logic [`BP_BPV_W-1:0]  bpv_2x1_p0,
  output logic [`BP_BPV_W-1:0]  bpv_2x1_p1,
  output logic [`BP_FULL_W-1:0] bp_bits
);

  localparam int HEAD_W = `BP_HEAD_W;
  localparam int FULL_W = `BP_FULL_W;
  localparam int BPV_W  = `BP_BPV_W;

  localparam logic [BPV_W-1:0] FLS_OFS = BPV_W'(`BP_FLS_OFFSET);

  logic [HEAD_W-1:0] payload;
  logic              is_bp;
  logic              one_vec;
  logic [BPV_W-1:0]  vec_a;
  logic [BPV_W-1:0]  vec_b;
  logic [BPV_W-1:0]  ofs;
  logic [FULL_W-1:0] bpv_len;

  // flags and vectors start right after the mode and flatness fields
  assign payload = head << hdr_bits;
  assign is_bp   = mode == bit_parse_pkg::mode_bp;

  // flag 0 is the first bit read
  assign use_2x2 = is_bp ? {payload[HEAD_W-4], payload[HEAD_W-3],
                            payload[HEAD_W-2], payload[HEAD_W-1]} : 4'd0;
  assign one_vec = payload[HEAD_W-1];

  // fls blocks use one bit less per vector
  assign vec_a = is_next_block_fls ? {1'b0, payload[HEAD_W-5 -: BPV_W-1]}
                                   : payload[HEAD_W-5 -: BPV_W];
  assign vec_b = is_next_block_fls ? {1'b0, payload[HEAD_W-5-(BPV_W-1) -: BPV_W-1]}
                                   : payload[HEAD_W-5-BPV_W -: BPV_W];

  assign ofs     = is_next_block_fls ? FLS_OFS : '0;
  assign bpv_len = is_next_block_fls ? FULL_W'(BPV_W-1) : FULL_W'(BPV_W);

  // flag 0 set: one 2x2 vector, else two 2x1 vectors with p1 first
  assign bpv_2x2    = (is_bp && one_vec) ? vec_a + ofs : '0;
  assign bpv_2x1_p1 = (is_bp && !one_vec) ? vec_a + ofs : '0;
  assign bpv_2x1_p0 = (is_bp && !one_vec) ? vec_b + ofs : '0;

  always_comb
  begin
    if (!is_bp)
    begin
      bp_bits = '0;
    end
    else if (one_vec)
    begin
      bp_bits = FULL_W'(4) + bpv_len;
    end
    else
    begin
      bp_bits = FULL_W'(4) + (bpv_len << 1);
    end
  end

endmodule

//--- mode_header_dec.sv
`include "bit_parse_settings.svh"

module mode_header_dec
(
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  parse_en,
  input  bit_parse_pkg::head_u  head,
  input  logic [`BP_FULL_W-1:0] bp_bits,
  input  logic [`BP_FULL_W-1:0] mpp_bits,
  input  logic                  is_next_block_fls,
  output bit_parse_pkg::mode_e  mode,
  output logic [2:0]            flat_type,
  output logic [`BP_FULL_W-1:0] hdr_bits,
  output logic [`BP_FULL_W-1:0] block_bits
);

  localparam int FULL_W = `BP_FULL_W;

  bit_parse_pkg::mode_e prev_mode;
  logic [1:0]           code;
  logic                 flat_flag;
  logic [1:0]           flat_code;
  logic [FULL_W-1:0]    mode_hdr_bits;
  logic [FULL_W-1:0]    flat_hdr_bits;
  logic [FULL_W-1:0]    intra_bits;

  assign code = head.new_hdr.mode_code;

  always_comb
  begin
    if (head.same_hdr.same)
    begin
      mode          = prev_mode;
      mode_hdr_bits = FULL_W'(1);
      flat_flag     = head.same_hdr.flat_flag;
      flat_code     = head.same_hdr.flat_type;
    end
    else if (code == 2'd3)
    begin
      // escape bit picks bpskip over mppf
      mode          = head.new_hdr.esc ? bit_parse_pkg::mode_bpskip
                                       : bit_parse_pkg::mode_mppf;
      mode_hdr_bits = FULL_W'(4);
      flat_flag     = head.new_hdr.flat_flag;
      flat_code     = head.new_hdr.flat_type;
    end
    else
    begin
      // no escape bit, flatness sits one bit higher
      mode          = bit_parse_pkg::mode_e'({1'b0, code});
      mode_hdr_bits = FULL_W'(3);
      flat_flag     = head.new_hdr.esc;
      flat_code     = {head.new_hdr.flat_flag, head.new_hdr.flat_type[1]};
    end
  end

  // type 4 marks a block without a flatness type
  assign flat_type     = flat_flag ? {1'b0, flat_code} : 3'd4;
  assign flat_hdr_bits = flat_flag ? FULL_W'(3) : FULL_W'(1);
  assign hdr_bits      = mode_hdr_bits + flat_hdr_bits;

  // intra mode field is skipped in fls blocks
  assign intra_bits = is_next_block_fls ? '0 : FULL_W'(3);

  always_comb
  begin
    case (mode)
      bit_parse_pkg::mode_mpp:
      begin
        block_bits = hdr_bits + mpp_bits;
      end
      bit_parse_pkg::mode_bp:
      begin
        block_bits = hdr_bits + bp_bits;
      end
      bit_parse_pkg::mode_mppf:
      begin
        // one type bit then the fixed residual
        block_bits = hdr_bits + FULL_W'(1) + FULL_W'(`BP_MPPF_RES_BITS);
      end
      default:
      begin
        block_bits = hdr_bits + intra_bits;
      end
    endcase
  end

  // mode remembered for the next same-flag header
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      prev_mode <= bit_parse_pkg::mode_xfm;
    end
    else if (parse_en)
    begin
      prev_mode <= mode;
    end
  end

  // known and legal, also for modes carried over through prev_mode
  a_mode_legal: assert property (
    @(posedge clk) disable iff (!rstn)
    parse_en |-> !$isunknown(mode) && mode <= bit_parse_pkg::mode_bpskip
  ) else $error("illegal block mode %0d", mode);

endmodule

//--- bit_funnel.sv
`include "bit_parse_settings.svh"

module bit_funnel
(
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  start_dec,
  input  logic                  data_avail,
  input  logic [`BP_WORD_W-1:0] data,
  input  logic [`BP_FULL_W-1:0] block_bits,
  output logic                  data_rd_en,
  output logic                  parse_en,
  output bit_parse_pkg::head_u  head
);

  localparam int WORD_W   = `BP_WORD_W;
  localparam int FUNNEL_W = `BP_FUNNEL_W;
  localparam int FULL_W   = `BP_FULL_W;
  localparam int HEAD_W   = `BP_HEAD_W;

  logic [FUNNEL_W-1:0] funnel;
  logic [FULL_W-1:0]   fullness;
  logic [FULL_W-1:0]   consumed;
  logic [FULL_W-1:0]   remain;
  logic [FUNNEL_W-1:0] shifted;
  logic [FUNNEL_W-1:0] keep_mask;
  logic [FUNNEL_W-1:0] placed;
  logic [FUNNEL_W-1:0] funnel_nxt;

  // a full word in the funnel covers the largest block
  assign parse_en = fullness >= FULL_W'(WORD_W);

  assign consumed = parse_en ? block_bits : '0;
  assign remain   = fullness - consumed;

  // pull a word once the survivors leave room for it
  assign data_rd_en = start_dec & data_avail & (remain < FULL_W'(WORD_W));

  // drop the bits of the current block
  assign shifted = funnel << consumed;

  // only the top remain bits survive a refill
  assign keep_mask = ~({FUNNEL_W{1'b1}} >> remain);

  // new word lands right behind the surviving bits
  assign placed = {data, {(FUNNEL_W-WORD_W){1'b0}}} >> remain;

  always_comb
  begin
    if (data_rd_en)
    begin
      funnel_nxt = (shifted & keep_mask) | placed;
    end
    else
    begin
      funnel_nxt = shifted;
    end
  end

  always_ff @(posedge clk)
  begin
    funnel <= funnel_nxt;
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      fullness <= '0;
    end
    else if (data_rd_en)
    begin
      fullness <= remain + FULL_W'(WORD_W);
    end
    else
    begin
      fullness <= remain;
    end
  end

  assign head = funnel[FUNNEL_W-1 -: HEAD_W];

  // with words flowing in, the funnel keeps at least one word
  a_keeps_word: assert property (
    @(posedge clk) disable iff (!rstn)
    parse_en && start_dec && data_avail |=> parse_en
  ) else $error("funnel fell below %0d bits while data was available", WORD_W);

  // decoded length must be covered by bits already loaded
  a_block_fits: assert property (
    @(posedge clk) disable iff (!rstn)
    parse_en |-> block_bits <= fullness
  ) else $error("block of %0d bits exceeds fullness %0d", block_bits, fullness);

endmodule

//--- bit_parse_pkg.sv
`include "bit_parse_settings.svh"

package bit_parse_pkg;

  // block coding modes, codes 0..2 come straight from the header
  typedef enum logic [2:0] {
    mode_xfm    = 3'd0,
    mode_bp     = 3'd1,
    mode_mpp    = 3'd2,
    mode_mppf   = 3'd3,
    mode_bpskip = 3'd4
  } mode_e;

  // same flag set, mode is inherited and flatness follows at once
  typedef struct packed {
    logic                  same;
    logic                  flat_flag;
    logic [1:0]            flat_type;
    logic [`BP_HEAD_W-5:0] payload;
  } hdr_same_s;

  // same flag clear, explicit mode code
  // the escape bit only exists for code 3, otherwise it is the flatness flag
  typedef struct packed {
    logic                  same;
    logic [1:0]            mode_code;
    logic                  esc;
    logic                  flat_flag;
    logic [1:0]            flat_type;
    logic [`BP_HEAD_W-8:0] payload;
  } hdr_new_s;

  // top of the funnel window, read through whichever view the same flag selects
  typedef union packed {
    hdr_same_s same_hdr;
    hdr_new_s  new_hdr;
  } head_u;

endpackage

//--- bit_parse_settings.svh
`ifndef BIT_PARSE_SETTINGS_SVH
`define BIT_PARSE_SETTINGS_SVH

// one codec buffer word
`define BP_WORD_W        128

// funnel holds up to one word plus 127 leftover bits
`define BP_FUNNEL_W      255

// fullness and every bit count
`define BP_FULL_W        8

// window seen by the decoders
// covers the worst BP header: 6 header bits, 4 flags, two 6-bit vectors
`define BP_HEAD_W        24

// block prediction vector output width
`define BP_BPV_W         6

// samples per block, sets the MPP residual length
`define BP_NUM_SAMPLES   16

// fixed residual size of an MPPF block
`define BP_MPPF_RES_BITS 32

// added to every vector when the next block is fullness limited
`define BP_FLS_OFFSET    32

`endif
